/* design/fxp_pkg.sv */
package fxp_pkg;

    // Q8.7 signed fixed point
    localparam int FXP_W     = 16;
    localparam int FRAC_BITS = 7;
    localparam int PROD_W    = 2 * FXP_W;

    typedef logic signed [FXP_W-1:0]  fxp_t;
    typedef logic signed [PROD_W-1:0] prod_t;

    // Half an LSB of the result, added before truncation
    localparam prod_t ROUND_BIAS = prod_t'(1) << (FRAC_BITS - 1);

    // One request, x0*y0 + x1*y1
    typedef struct packed {
        fxp_t x0;
        fxp_t y0;
        fxp_t x1;
        fxp_t y1;
    } dot2_req_t;

    typedef struct packed {
        fxp_t value;
        logic overflow;
    } dot2_rsp_t;

    typedef enum logic {
        idle,
        run
    } mul_state_t;

endpackage

/* design/fxp_adder.sv */
`timescale 1ns/1ps

module fxp_adder #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             carry_in,
    output logic [WIDTH-1:0] sum,
    output logic             carry_out
);

    logic [WIDTH:0] carry;

    assign carry[0] = carry_in;

    // One full adder per bit, carry ripples upward
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        logic half_sum;

        assign half_sum     = a[i] ^ b[i];
        assign sum[i]       = half_sum ^ carry[i];
        assign carry[i + 1] = (a[i] & b[i]) | (carry[i] & half_sum);
    end

    assign carry_out = carry[WIDTH];

endmodule

/* design/booth_multiplier.sv */
`timescale 1ns/1ps

module booth_multiplier (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  fxp_pkg::fxp_t multiplicand,
    input  fxp_pkg::fxp_t multiplier,
    output fxp_pkg::fxp_t product,
    output logic          overflow,
    output logic          busy,
    output logic          done
);

    import fxp_pkg::*;

    localparam int CNT_W = $clog2(FXP_W);

    mul_state_t       state;
    fxp_t             mcand_q;
    fxp_t             acc_hi;
    logic [FXP_W:0]   acc_lo;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             count_wrap;
    logic             load;
    logic             step;
    fxp_t             mcand_neg;
    fxp_t             addend;
    fxp_t             partial;
    prod_t            rounded;
    logic [PROD_W-FXP_W-FRAC_BITS:0] high_bits;

    assign load = start && (state == idle);
    assign step = (state == run);

    // Two's complement of the multiplicand, ~m + 1
    fxp_adder #(.WIDTH(FXP_W)) u_negate (
        .a         (~mcand_q),
        .b         ('0),
        .carry_in  (1'b1),
        .sum       (mcand_neg),
        .carry_out ()
    );

    // Booth pair 01 adds m, 10 subtracts m
    always_comb begin
        case (acc_lo[1:0])
            2'b01:   addend = mcand_q;
            2'b10:   addend = mcand_neg;
            default: addend = '0;
        endcase
    end

    fxp_adder #(.WIDTH(FXP_W)) u_partial (
        .a         (acc_hi),
        .b         (addend),
        .carry_in  (1'b0),
        .sum       (partial),
        .carry_out ()
    );

    fxp_adder #(.WIDTH(PROD_W)) u_round (
        .a         ({acc_hi, acc_lo[FXP_W:1]}),
        .b         (ROUND_BIAS),
        .carry_in  (1'b0),
        .sum       (rounded),
        .carry_out ()
    );

    fxp_adder #(.WIDTH(CNT_W)) u_counter (
        .a         (count),
        .b         (CNT_W'(1)),
        .carry_in  (1'b0),
        .sum       (count_next),
        .carry_out (count_wrap)
    );

    assign product   = rounded[FXP_W+FRAC_BITS-1:FRAC_BITS];
    // Bits above the result must all repeat its sign bit
    assign high_bits = rounded[PROD_W-1:FXP_W+FRAC_BITS-1];
    assign overflow  = !((&high_bits) || !(|high_bits));
    assign busy      = step || done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        count <= '0;
                    end
                end
                run: begin
                    count <= count_next;
                    // Sixteenth step wraps the counter
                    if (count_wrap) begin
                        state <= idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Accumulator shifts right arithmetically after each add
    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q <= multiplicand;
            acc_hi  <= '0;
            acc_lo  <= {multiplier, 1'b0};
        end else if (step) begin
            acc_hi <= {partial[FXP_W-1], partial[FXP_W-1:1]};
            acc_lo <= {partial[0], acc_lo[FXP_W:1]};
        end
    end

endmodule

/* design/dot2_combiner.sv */
`timescale 1ns/1ps

module dot2_combiner #(
    parameter int OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               done_a,
    input  logic               done_b,
    input  fxp_pkg::fxp_t      product_a,
    input  fxp_pkg::fxp_t      product_b,
    input  logic               overflow_a,
    input  logic               overflow_b,
    input  logic               out_credit,
    output logic               hold_free,
    output logic               out_valid,
    output fxp_pkg::dot2_rsp_t out_rsp
);

    import fxp_pkg::*;

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [FXP_W:0]   sum_ext;
    logic             saturate;
    logic             capture;
    logic             send;
    logic             held;
    logic [CNT_W-1:0] credit_cnt;
    dot2_rsp_t        rsp_next;
    dot2_rsp_t        rsp_q;

    assign capture = done_a && done_b;

    // One guard bit catches a sum outside the 16-bit range
    assign sum_ext  = {product_a[FXP_W-1], product_a} + {product_b[FXP_W-1], product_b};
    assign saturate = sum_ext[FXP_W] != sum_ext[FXP_W-1];

    always_comb begin
        rsp_next.overflow = overflow_a || overflow_b || saturate;
        if (!saturate) begin
            rsp_next.value = sum_ext[FXP_W-1:0];
        end else if (sum_ext[FXP_W]) begin
            rsp_next.value = {1'b1, {(FXP_W-1){1'b0}}};
        end else begin
            rsp_next.value = {1'b0, {(FXP_W-1){1'b1}}};
        end
    end

    // A held result leaves as soon as a credit is available
    assign send      = held && (credit_cnt != '0);
    assign out_valid = send;
    assign out_rsp   = rsp_q;
    assign hold_free = !held || send;

    always_ff @(posedge clk) begin
        if (rst) begin
            held       <= 1'b0;
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            if (capture) begin
                held <= 1'b1;
            end else if (send) begin
                held <= 1'b0;
            end

            case ({send, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rsp_q <= rsp_next;
        end
    end

endmodule

/* design/dot2_unit.sv */
`timescale 1ns/1ps

module dot2_unit #(
    parameter int IN_CREDITS  = 2,
    parameter int OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  fxp_pkg::dot2_req_t in_req,
    output logic               in_credit,
    output logic               out_valid,
    output fxp_pkg::dot2_rsp_t out_rsp,
    input  logic               out_credit
);

    import fxp_pkg::*;

    localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
    localparam int CNT_W = $clog2(IN_CREDITS + 1);

    dot2_req_t        queue_mem [IN_CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             q_empty;
    dot2_req_t        head;
    logic             issue;
    logic             hold_free;
    logic             busy_0;
    logic             busy_1;
    logic             done_0;
    logic             done_1;
    logic             ovf_0;
    logic             ovf_1;
    fxp_t             product_0;
    fxp_t             product_1;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(IN_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign q_empty = (q_count == '0);
    assign head    = queue_mem[rd_ptr];

    // Both multipliers and the combiner must be free before a request leaves
    assign issue     = !q_empty && !busy_0 && !busy_1 && hold_free;
    assign in_credit = issue;

    // Sender credits keep the queue from overflowing
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({in_valid, issue})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue_mem[wr_ptr] <= in_req;
        end
    end

    booth_multiplier u_mul_0 (
        .clk          (clk),
        .rst          (rst),
        .start        (issue),
        .multiplicand (head.x0),
        .multiplier   (head.y0),
        .product      (product_0),
        .overflow     (ovf_0),
        .busy         (busy_0),
        .done         (done_0)
    );

    booth_multiplier u_mul_1 (
        .clk          (clk),
        .rst          (rst),
        .start        (issue),
        .multiplicand (head.x1),
        .multiplier   (head.y1),
        .product      (product_1),
        .overflow     (ovf_1),
        .busy         (busy_1),
        .done         (done_1)
    );

    dot2_combiner #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_combiner (
        .clk        (clk),
        .rst        (rst),
        .done_a     (done_0),
        .done_b     (done_1),
        .product_a  (product_0),
        .product_b  (product_1),
        .overflow_a (ovf_0),
        .overflow_b (ovf_1),
        .out_credit (out_credit),
        .hold_free  (hold_free),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp)
    );

endmodule

/* tests/dot2_unit_sva.sv */
`timescale 1ns/1ps

module dot2_unit_sva #(
    parameter int OUT_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit,
    input logic done_0,
    input logic done_1
);

    int accepted;
    int returned_in;
    int out_held;
    int fail_count = 0;

    // Shadow counts of both credit loops
    always @(posedge clk) begin
        if (rst) begin
            accepted    <= 0;
            returned_in <= 0;
            out_held    <= OUT_CREDITS;
        end else begin
            accepted    <= accepted + int'(in_valid);
            returned_in <= returned_in + int'(in_credit);
            out_held    <= out_held - int'(out_valid) + int'(out_credit);
        end
    end

    a_done_lockstep: assert property (@(posedge clk) disable iff (rst) done_0 == done_1)
        else begin
            $error("multiplier done pulses out of step");
            fail_count++;
        end

    a_out_credit: assert property (@(posedge clk) disable iff (rst) out_valid |-> out_held > 0)
        else begin
            $error("out_valid raised with no output credit held");
            fail_count++;
        end

    a_in_credit: assert property (@(posedge clk) disable iff (rst)
        in_credit |-> returned_in < accepted)
        else begin
            $error("in_credit returned more credits than requests accepted");
            fail_count++;
        end

endmodule

bind dot2_unit dot2_unit_sva #(
    .OUT_CREDITS (OUT_CREDITS)
) u_sva (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .done_0     (done_0),
    .done_1     (done_1)
);

/* tests/dot2_unit_tb.sv */
`timescale 1ns/1ps

module dot2_unit_tb;

    import fxp_pkg::*;

    localparam int IN_CREDITS  = 2;
    localparam int OUT_CREDITS = 2;
    localparam int WAIT_LIMIT  = 5000;
    localparam int RANDOM_REQS = 300;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        in_valid = 1'b0;
    dot2_req_t   in_req = '0;
    logic        in_credit;
    logic        out_valid;
    dot2_rsp_t   out_rsp;
    logic        out_credit = 1'b0;

    logic [15:0] lfsr_state = 16'd10807;
    dot2_rsp_t   exp_q [$];
    dot2_rsp_t   last_rsp;
    int          sent_count = 0;
    int          credit_count = 0;
    int          rsp_count = 0;
    int          returned_count = 0;
    logic        credits_enabled = 1'b1;
    logic        release_credit = 1'b0;

    dot2_unit #(
        .IN_CREDITS  (IN_CREDITS),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_dot2_unit (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .out_credit (out_credit)
    );

    always #2 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic logic [15:0] rand_bits(input int count);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[14:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Random shift spreads magnitudes so some products stay in range
    function automatic fxp_t rand_operand(input logic is_multiplicand);
        fxp_t value;
        value = rand_bits(16);
        value = value >>> rand_bits(3);
        // Booth negation of the most negative multiplicand does not fit
        if (is_multiplicand && value == 16'h8000) begin
            value = 16'h8001;
        end
        return value;
    endfunction

    function automatic dot2_req_t random_req();
        dot2_req_t req;
        req.x0 = rand_operand(1'b1);
        req.y0 = rand_operand(1'b0);
        req.x1 = rand_operand(1'b1);
        req.y1 = rand_operand(1'b0);
        return req;
    endfunction

    function automatic dot2_req_t make_req(input fxp_t x0, input fxp_t y0,
                                           input fxp_t x1, input fxp_t y1);
        dot2_req_t req;
        req.x0 = x0;
        req.y0 = y0;
        req.x1 = x1;
        req.y1 = y1;
        return req;
    endfunction

    function automatic dot2_rsp_t make_rsp(input fxp_t value, input logic overflow);
        dot2_rsp_t rsp;
        rsp.value    = value;
        rsp.overflow = overflow;
        return rsp;
    endfunction

    // Exact product, add half an LSB, keep bits 22 to 7
    function automatic dot2_rsp_t rounded_product(input fxp_t a, input fxp_t b);
        logic signed [31:0] exact;
        logic signed [31:0] biased;
        dot2_rsp_t          r;
        exact      = a * b;
        biased     = exact + 32'sd64;
        r.value    = biased[22:7];
        r.overflow = (biased[31:22] != 10'h000) && (biased[31:22] != 10'h3FF);
        return r;
    endfunction

    function automatic dot2_rsp_t expected_rsp(input dot2_req_t req);
        dot2_rsp_t          p0;
        dot2_rsp_t          p1;
        dot2_rsp_t          r;
        logic signed [16:0] total;
        p0         = rounded_product(req.x0, req.y0);
        p1         = rounded_product(req.x1, req.y1);
        total      = {p0.value[15], p0.value} + {p1.value[15], p1.value};
        r.overflow = p0.overflow | p1.overflow;
        if (total > 17'sd32767) begin
            r.value    = 16'h7FFF;
            r.overflow = 1'b1;
        end else if (total < -17'sd32768) begin
            r.value    = 16'h8000;
            r.overflow = 1'b1;
        end else begin
            r.value = total[15:0];
        end
        return r;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_rsp(input dot2_rsp_t got, input dot2_rsp_t expected);
        if (got !== expected) begin
            fail_run($sformatf("ERROR: out_rsp value %h overflow %h, expected value %h overflow %h",
                               got.value, got.overflow, expected.value, expected.overflow));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            fail_run($sformatf("ERROR: %s got %h, expected %h", name, got, expected));
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            fail_run($sformatf("ERROR: %s count got %h, expected %h", name, got, expected));
        end
    endtask

    // Sender side, called on a falling edge
    task automatic send_req(input dot2_req_t req);
        int waited;
        waited = 0;
        while (IN_CREDITS + credit_count - sent_count <= 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timed out waiting for an input credit");
            end
        end
        in_valid = 1'b1;
        in_req   = req;
        sent_count++;
        exp_q.push_back(expected_rsp(req));
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_responses(input int target);
        int waited;
        waited = 0;
        while (rsp_count < target) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timed out waiting for responses");
            end
        end
    endtask

    task automatic wait_credits_back();
        int waited;
        waited = 0;
        while (returned_count < rsp_count) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timed out waiting for the receiver to return its credits");
            end
        end
    endtask

    task automatic run_directed(input dot2_req_t req, input dot2_rsp_t expected);
        send_req(req);
        wait_responses(sent_count);
        check_rsp(last_rsp, expected);
    endtask

    // Monitor and compare on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (in_credit) begin
                credit_count++;
            end
            if (out_credit) begin
                returned_count++;
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("out_valid raised with no request outstanding");
                end else begin
                    last_rsp = out_rsp;
                    check_rsp(out_rsp, exp_q.pop_front());
                    rsp_count++;
                end
            end
        end
    end

    // Receiver holds each credit for a random time
    always @(posedge clk) begin
        release_credit = (rand_bits(5) == 16'd0) && credits_enabled;
    end

    always @(negedge clk) begin
        out_credit = 1'b0;
        if (!rst && release_credit && returned_count < rsp_count) begin
            out_credit = 1'b1;
        end
    end

    initial begin
        int base;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("in_credit", in_credit, 1'b0);
        end

        run_directed(make_req(16'h0080, 16'h0080, 16'h0000, 16'h0000), make_rsp(16'h0080, 1'b0));
        run_directed(make_req(16'hFF40, 16'h0100, 16'h0020, 16'h0040), make_rsp(16'hFE90, 1'b0));
        // Rounding boundary, half an LSB either side
        run_directed(make_req(16'h0001, 16'h0040, 16'h0001, 16'h003F), make_rsp(16'h0001, 1'b0));
        run_directed(make_req(16'hFFFF, 16'h0040, 16'hFFFF, 16'h0041), make_rsp(16'hFFFF, 1'b0));
        // 100.0 times 100.0
        run_directed(make_req(16'h3200, 16'h3200, 16'h0000, 16'h0000), make_rsp(16'h8800, 1'b1));
        // 144.0 twice saturates the sum
        run_directed(make_req(16'h0600, 16'h0600, 16'h0600, 16'h0600), make_rsp(16'h7FFF, 1'b1));
        run_directed(make_req(16'hFA00, 16'h0600, 16'h0600, 16'hFA00), make_rsp(16'h8000, 1'b1));

        for (int i = 0; i < RANDOM_REQS; i++) begin
            send_req(random_req());
            repeat (int'(rand_bits(2))) @(negedge clk);
        end
        wait_responses(sent_count);
        wait_credits_back();

        // Receiver stops returning credits
        credits_enabled = 1'b0;
        base = rsp_count;
        for (int i = 0; i < 5; i++) begin
            send_req(random_req());
        end
        wait_responses(base + OUT_CREDITS);
        repeat (60) begin
            @(negedge clk);
            check_count("stalled response", rsp_count, base + OUT_CREDITS);
        end
        credits_enabled = 1'b1;
        wait_responses(sent_count);
        wait_credits_back();

        check_count("in_credit", credit_count, sent_count);
        check_count("response", rsp_count, sent_count);
        check_count("pending response", exp_q.size(), 0);

        if (u_dot2_unit.u_sva.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Bound assertions failed %0d times", u_dot2_unit.u_sva.fail_count);
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* compile.f */
design/fxp_pkg.sv
design/fxp_adder.sv
design/booth_multiplier.sv
design/dot2_combiner.sv
design/dot2_unit.sv
tests/dot2_unit_sva.sv
tests/dot2_unit_tb.sv
